// File: calc_top.f
calc_pkg.sv
calc_regs.sv
calc_accum.sv
calc_ctrl.sv
calc_top.sv
tb_calc.sv

// File: Makefile
# Verilator build and run of the calculator testbench

VERILATOR ?= verilator
TOP       ?= tb_calc
FILELIST  ?= calc_top.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= TEST PASSED

SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

# output goes to the terminal, the status comes from the search
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: tb_calc.sv
// calculator testbench
`timescale 1ns/1ps

module tb_calc;
  import calc_pkg::*;

  localparam int READY_LIMIT = 20;    // cycles until o_ready_e
  localparam int WORD_LIMIT  = 4000;  // cycles to drain all words
  localparam int N_RANDOM    = 40;

  logic        clk;
  logic        rst_n;
  calc_word_t  i_x, i_y;
  calc_op_t    i_op;
  logic        i_start_v;
  logic        i_output_e;
  logic        o_ready_e;
  calc_word_t  o_result;
  logic        o_done_v;

  logic [31:0] rng;                  // xorshift state
  int          n_cmds;               // commands read back by the stimulus
  int          timeouts;
  int          err_reset   = 0;
  int          err_idle    = 0;
  int          err_busy    = 0;
  int          err_latency = 0;
  int          err_value   = 0;
  int          err_hold    = 0;
  int          err_start   = 0;
  int          err_count   = 0;

  // command in flight, tracked from the ports
  logic        busy;
  int          edges;                // edges since acceptance
  int          word_idx;             // 0 first word, 1 second
  int          done_cmds;
  calc_op_t    cmd_op;
  calc_word_t  cmd_x, cmd_y;
  calc_word_t  exp_word;
  int          exp_lat;

  calc_top dut0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_x        (i_x),
    .i_y        (i_y),
    .i_op       (i_op),
    .i_start_v  (i_start_v),
    .o_ready_e  (o_ready_e),
    .o_result   (o_result),
    .o_done_v   (o_done_v),
    .i_output_e (i_output_e)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 8 ns period
  end

  //////////////////// reference

  function automatic int words_per_cmd(input calc_op_t op);
    return (op == CALC_OP_MUL || op == CALC_OP_DIV) ? 2 : 1;
  endfunction

  function automatic int done_latency(input calc_op_t op);
    return (op == CALC_OP_MUL || op == CALC_OP_DIV) ? CALC_BITS + 3 : 3;
  endfunction

  // word idx of the result, spare codes run as add
  function automatic calc_word_t expected_word(input calc_op_t op, input calc_word_t x,
                                               input calc_word_t y, input int idx);
    calc_dword_t prod;
    prod = calc_dword_t'(x) * calc_dword_t'(y);  // full width product
    case (op)
      CALC_OP_SUB: return x - y;
      CALC_OP_MUL: return (idx == 0) ? prod[CALC_BITS-1:0] : prod[2*CALC_BITS-1:CALC_BITS];
      CALC_OP_DIV: begin
        if (y == '0) begin
          return (idx == 0) ? '1 : x;  // divide by zero
        end
        return (idx == 0) ? x / y : x % y;
      end
      default:     return x + y;
    endcase
  endfunction

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] v;
    v = s;
    v = v ^ (v << 13);
    v = v ^ (v >> 17);
    v = v ^ (v << 5);
    return v;
  endfunction

  function logic [31:0] next_random();
    rng = xorshift32(rng);
    return rng;
  endfunction

  function calc_word_t random_word();
    logic [63:0] w;
    w = {next_random(), next_random()};
    return calc_word_t'(w);  // low bits for narrow words
  endfunction

  assign exp_word = expected_word(cmd_op, cmd_x, cmd_y, word_idx);
  assign exp_lat  = done_latency(cmd_op);

  //////////////////// monitor

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy      <= 1'b0;
      edges     <= 0;
      word_idx  <= 0;
      done_cmds <= 0;
      cmd_op    <= CALC_OP_ADD;
      cmd_x     <= '0;
      cmd_y     <= '0;
    end else if (!busy) begin
      if (o_ready_e && i_start_v) begin  // acceptance edge
        busy     <= 1'b1;
        edges    <= 0;
        word_idx <= 0;
        cmd_op   <= i_op;
        cmd_x    <= i_x;
        cmd_y    <= i_y;
      end
    end else begin
      edges <= edges + 1;
      if (o_done_v && i_output_e) begin
        if (word_idx == words_per_cmd(cmd_op) - 1) begin
          busy      <= 1'b0;  // last word gone
          done_cmds <= done_cmds + 1;
        end else begin
          word_idx <= word_idx + 1;
        end
      end
    end
  end

  //////////////////// checks

  a_reset_idle: assert property (@(posedge clk) !rst_n |-> !o_done_v && o_ready_e)
    else begin
      err_reset++;
      $display("[ERROR] %0t outputs not idle during reset", $time);
    end

  // also covers the first edge after reset and the edge after the last word
  a_idle: assert property (@(posedge clk) disable iff (!rst_n)
    !busy |-> o_ready_e && !o_done_v)
    else begin
      err_idle++;
      $display("[ERROR] %0t not ready or done high with no command", $time);
    end

  a_busy: assert property (@(posedge clk) disable iff (!rst_n) busy |-> !o_ready_e)
    else begin
      err_busy++;
      $display("[ERROR] %0t ready high while a command runs", $time);
    end

  a_latency: assert property (@(posedge clk) disable iff (!rst_n)
    busy && $rose(o_done_v) |-> edges == exp_lat)
    else begin
      err_latency++;
      $display("[ERROR] %0t done after %0d edges, expected %0d", $time,
               $sampled(edges), $sampled(exp_lat));
    end

  a_value: assert property (@(posedge clk) disable iff (!rst_n)
    busy && o_done_v |-> o_result == exp_word)
    else begin
      err_value++;
      $display("[ERROR] %0t result %h, expected %h", $time,
               $sampled(o_result), $sampled(exp_word));
    end

  // back-pressure holds the word
  a_hold: assert property (@(posedge clk) disable iff (!rst_n)
    o_done_v && !i_output_e |=> o_done_v && $stable(o_result))
    else begin
      err_hold++;
      $display("[ERROR] %0t result or done moved while not accepted", $time);
    end

  a_start: assert property (@(posedge clk) disable iff (!rst_n)
    !o_ready_e && i_start_v && !(o_done_v && i_output_e) |=> !o_ready_e)
    else begin
      err_start++;
      $display("[ERROR] %0t start taken while busy", $time);
    end

  //////////////////// stimulus

  // one command, then drain its words under random accept and start noise
  task run_cmd(input calc_op_t op, input calc_word_t x, input calc_word_t y);
    int          n;
    int          taken;
    logic [31:0] r;
    if (timeouts != 0) begin
      return;
    end
    @(posedge clk);
    i_op      <= op;
    i_x       <= x;
    i_y       <= y;
    i_start_v <= 1'b1;
    n = 0;
    @(negedge clk);
    while (!o_ready_e && n < READY_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (!o_ready_e) begin
      $display("timeout: DUT did not become ready for a new command");
      timeouts++;
      return;
    end
    taken = 0;
    n = 0;
    while (taken < words_per_cmd(op) && n < WORD_LIMIT) begin
      @(posedge clk);              // first pass is the accepting edge
      r = next_random();
      i_start_v  <= r[0];          // ignored while busy
      i_op       <= calc_op_t'(r[3:1]);
      i_x        <= random_word();
      i_y        <= random_word();
      i_output_e <= r[4];
      @(negedge clk);
      if (o_done_v && i_output_e) begin
        taken++;
      end
      n++;
    end
    if (taken < words_per_cmd(op)) begin
      $display("timeout: result words did not all arrive");
      timeouts++;
      return;
    end
    n_cmds++;
  endtask

  initial begin
    logic [31:0] r;
    calc_word_t  y;
    int          k;
    int          total;
    rng        = 32'd30;
    n_cmds     = 0;
    timeouts   = 0;
    rst_n      = 1'b0;
    i_x        = '0;
    i_y        = '0;
    i_op       = CALC_OP_ADD;
    i_start_v  = 1'b0;
    i_output_e = 1'b0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;

    // edge values
    run_cmd(CALC_OP_ADD, '0, '0);
    run_cmd(CALC_OP_ADD, '1, calc_word_t'(1));   // wraps to zero
    run_cmd(CALC_OP_SUB, '0, calc_word_t'(1));
    run_cmd(CALC_OP_MUL, '1, '1);
    run_cmd(CALC_OP_MUL, '0, random_word());
    run_cmd(CALC_OP_DIV, random_word(), '0);     // divisor zero
    run_cmd(CALC_OP_DIV, '0, calc_word_t'(7));
    run_cmd(CALC_OP_DIV, '1, calc_word_t'(1));
    run_cmd(CALC_OP_DIV, '1, '1);

    for (k = 0; k < N_RANDOM; k++) begin
      r = next_random();
      y = random_word();
      if (r[4]) begin
        y = y >> (CALC_BITS / 2);  // smaller divisor, wider quotient
      end
      run_cmd(calc_op_t'(r[2:0]), random_word(), y);
    end

    // quiet ports, let the last checks sample
    @(posedge clk);
    i_start_v  <= 1'b0;
    i_output_e <= 1'b0;
    repeat (3) @(posedge clk);
    if (timeouts == 0 && done_cmds != n_cmds) begin
      err_count++;
      $display("command count mismatch, %0d read back but %0d seen at the ports",
               n_cmds, done_cmds);
    end
    total = err_reset + err_idle + err_busy + err_latency + err_value + err_hold
          + err_start + err_count + timeouts;
    $write("errors reset=%0d idle=%0d busy=%0d latency=%0d value=%0d",
           err_reset, err_idle, err_busy, err_latency, err_value);
    $display(" hold=%0d start=%0d count=%0d timeout=%0d",
             err_hold, err_start, err_count, timeouts);
    if (total == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: calc_top.sv
// pinwheel calculator top
`timescale 1ns/1ps

module calc_top (
  input  logic                 clk,
  input  logic                 rst_n,
  input  calc_pkg::calc_word_t i_x,
  input  calc_pkg::calc_word_t i_y,
  input  calc_pkg::calc_op_t   i_op,
  input  logic                 i_start_v,
  output logic                 o_ready_e,
  output calc_pkg::calc_word_t o_result,
  output logic                 o_done_v,
  input  logic                 i_output_e
);
  import calc_pkg::*;

  // sequencer controls
  logic        load;
  calc_reg_t   rreg, wreg;
  calc_xop_t   xop;
  logic        x_shin;
  calc_yop_t   yop;
  logic        a_do, a_sub, a_clr, a_exec;

  // datapath status and cross links
  logic        carry, x_lsb;
  calc_word_t  bus;
  calc_dword_t y;
  calc_word_t  a_lo, a_hi;

  calc_ctrl u_ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_op       (i_op),
    .i_start_v  (i_start_v),
    .i_output_e (i_output_e),
    .i_carry    (carry),
    .i_x_lsb    (x_lsb),
    .o_ready_e  (o_ready_e),
    .o_done_v   (o_done_v),
    .o_load     (load),
    .o_rreg     (rreg),
    .o_wreg     (wreg),
    .o_xop      (xop),
    .o_x_shin   (x_shin),
    .o_yop      (yop),
    .o_a_do     (a_do),
    .o_a_sub    (a_sub),
    .o_a_clr    (a_clr),
    .o_a_exec   (a_exec)
  );

  calc_regs u_regs (
    .clk      (clk),
    .rst_n    (rst_n),
    .i_x      (i_x),
    .i_y      (i_y),
    .i_load   (load),
    .i_rreg   (rreg),
    .i_wreg   (wreg),
    .i_xop    (xop),
    .i_x_shin (x_shin),
    .i_yop    (yop),
    .i_a_lo   (a_lo),
    .i_a_hi   (a_hi),
    .o_bus    (bus),
    .o_y      (y),
    .o_x_lsb  (x_lsb),
    .o_result (o_result)
  );

  calc_accum u_accum (
    .clk     (clk),
    .rst_n   (rst_n),
    .i_bus   (bus),
    .i_wreg  (wreg),
    .i_y     (y),
    .i_do    (a_do),
    .i_sub   (a_sub),
    .i_clr   (a_clr),
    .i_exec  (a_exec),
    .o_a_lo  (a_lo),
    .o_a_hi  (a_hi),
    .o_carry (carry)
  );

endmodule

// File: calc_ctrl.sv
// calculator sequencer
`timescale 1ns/1ps

module calc_ctrl (
  input  logic                clk,
  input  logic                rst_n,
  input  calc_pkg::calc_op_t  i_op,
  input  logic                i_start_v,
  input  logic                i_output_e,  // consumer accept
  input  logic                i_carry,     // from accumulator adder
  input  logic                i_x_lsb,     // multiplier bit
  output logic                o_ready_e,
  output logic                o_done_v,
  output logic                o_load,
  output calc_pkg::calc_reg_t o_rreg,
  output calc_pkg::calc_reg_t o_wreg,
  output calc_pkg::calc_xop_t o_xop,
  output logic                o_x_shin,
  output calc_pkg::calc_yop_t o_yop,
  output logic                o_a_do,
  output logic                o_a_sub,
  output logic                o_a_clr,
  output logic                o_a_exec
);
  import calc_pkg::*;

  calc_phase_t curph_q, curph_d;
  calc_op_t    curop_q, curop_d;  // latched command
  calc_cnt_t   cnt_q, cnt_d;      // loop iterations left
  logic        done_v_d;
  logic        accept;            // word taken this edge

  assign accept    = o_done_v & i_output_e;
  assign o_ready_e = (curph_q == PH_RDY);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      curph_q  <= PH_RDY;
      curop_q  <= CALC_OP_ADD;
      cnt_q    <= calc_cnt_t'(CALC_BITS-1);
      o_done_v <= 1'b0;
    end else begin
      curph_q  <= curph_d;
      curop_q  <= curop_d;
      cnt_q    <= cnt_d;
      o_done_v <= done_v_d;
    end
  end

  //////////////////// phases

  always_comb begin
    curph_d  = curph_q;
    curop_d  = curop_q;
    cnt_d    = cnt_q;
    done_v_d = 1'b0;
    o_load   = 1'b0;
    o_rreg   = REG_ZERO;  // idle bus
    o_wreg   = REG_ZERO;
    o_xop    = XOP_NOP;
    o_x_shin = 1'b0;
    o_yop    = YOP_NOP;
    o_a_do   = 1'b0;
    o_a_sub  = 1'b0;
    o_a_clr  = 1'b0;
    o_a_exec = 1'b0;

    case (curph_q)
      PH_RDY: begin
        o_a_do  = 1'b1;      // keep A clear
        o_a_clr = 1'b1;
        o_wreg  = REG_Y_HI;  // Y hi from the zero reg
        if (i_start_v) begin
          o_load  = 1'b1;
          curop_d = i_op;
          curph_d = PH_START;
        end
      end

      PH_START: begin
        case (curop_q)
          CALC_OP_MUL: curph_d = PH_MULLOOP;  // A already zero
          CALC_OP_DIV: begin
            o_yop   = YOP_SHW;   // align divisor
            o_rreg  = REG_X;     // dividend into A
            o_wreg  = REG_A_LO;
            curph_d = PH_DIVLOOP;
          end
          CALC_OP_SUB: begin
            o_rreg  = REG_X;
            o_wreg  = REG_A_LO;
            curph_d = PH_SUB1;
          end
          default: begin         // add and spare codes
            o_rreg  = REG_X;
            o_wreg  = REG_A_LO;
            curph_d = PH_ADD1;
          end
        endcase
      end

      PH_ADD1, PH_SUB1: begin
        o_a_do   = 1'b1;
        o_a_exec = 1'b1;
        o_a_sub  = (curph_q == PH_SUB1);
        curph_d  = PH_OUPA;
      end

      // shift and add, Y walks up while X walks down
      PH_MULLOOP: begin
        o_a_do   = i_x_lsb;
        o_a_exec = 1'b1;
        o_yop    = YOP_SHL;
        o_xop    = XOP_SHR;
        if (cnt_q == '0) begin
          cnt_d   = calc_cnt_t'(CALC_BITS-1);
          curph_d = PH_MULOUT;
        end else begin
          cnt_d = cnt_q - 1'b1;
        end
      end

      PH_MULOUT: begin
        o_rreg  = REG_A_LO;  // product lo into Z
        o_wreg  = REG_Z;
        curph_d = PH_OUP2A;
      end

      // trial subtract, result kept only without borrow
      PH_DIVLOOP: begin
        o_a_sub  = 1'b1;
        o_a_exec = 1'b1;
        o_a_do   = i_carry;
        o_x_shin = i_carry;  // quotient bit
        o_xop    = XOP_SHL;
        if (cnt_q == '0) begin
          cnt_d   = calc_cnt_t'(CALC_BITS-1);
          curph_d = PH_DIVOUT;
        end else begin
          o_yop = YOP_SHR;  // next lower multiple
          cnt_d = cnt_q - 1'b1;
        end
      end

      PH_DIVOUT: begin
        o_rreg  = REG_X;  // quotient into Z
        o_wreg  = REG_Z;
        curph_d = PH_OUP2B;
      end

      //////////////////// output

      PH_OUPA: begin
        o_rreg   = REG_A_LO;
        o_wreg   = REG_Z;
        done_v_d = 1'b1;
        curph_d  = PH_OUPW;
      end

      // first word held in Z until taken, then the second
      PH_OUP2A, PH_OUP2B: begin
        done_v_d = 1'b1;
        if (accept) begin
          o_rreg  = (curph_q == PH_OUP2A) ? REG_A_HI : REG_A_LO;
          o_wreg  = REG_Z;
          curph_d = PH_OUPW;
        end
      end

      PH_OUPW: begin
        done_v_d = ~accept;
        if (accept) begin
          curph_d = PH_RDY;
        end
      end

      default: curph_d = PH_RDY;
    endcase
  end

  //////////////////// checks

  a_idle_no_done: assert property (@(posedge clk) disable iff (!rst_n)
    (curph_q == PH_RDY) |-> !o_done_v);

  // loop stays put until the counter runs out
  a_loop_exit: assert property (@(posedge clk) disable iff (!rst_n)
    ((curph_q == PH_MULLOOP || curph_q == PH_DIVLOOP) && cnt_q != '0) |=>
      (curph_q == $past(curph_q)));

endmodule

// File: calc_accum.sv
// double width accumulator
`timescale 1ns/1ps

module calc_accum (
  input  logic                  clk,
  input  logic                  rst_n,
  input  calc_pkg::calc_word_t  i_bus,
  input  calc_pkg::calc_reg_t   i_wreg,
  input  calc_pkg::calc_dword_t i_y,     // carriage
  input  logic                  i_do,    // update A
  input  logic                  i_sub,   // A - Y instead of A + Y
  input  logic                  i_clr,
  input  logic                  i_exec,  // take the adder result
  output calc_pkg::calc_word_t  o_a_lo,
  output calc_pkg::calc_word_t  o_a_hi,
  output logic                  o_carry  // no borrow when subtracting
);
  import calc_pkg::*;

  calc_dword_t          a_q, a_d;
  calc_dword_t          addend;
  logic [2*CALC_BITS:0] sum;     // one extra bit for carry
  logic                 lo_en, hi_en;

  //////////////////// adder

  assign addend  = i_sub ? ~i_y : i_y;  // twos complement with carry in
  assign sum     = {1'b0, a_q} + {1'b0, addend} + {{(2*CALC_BITS){1'b0}}, i_sub};
  assign o_carry = sum[2*CALC_BITS];

  //////////////////// update

  // later assignments win, clear on top
  always_comb begin
    a_d = a_q;
    if (i_wreg == REG_A_LO) begin
      a_d[CALC_BITS-1:0] = i_bus;
    end
    if (i_wreg == REG_A_HI) begin
      a_d[2*CALC_BITS-1:CALC_BITS] = i_bus;
    end
    if (i_exec) begin
      a_d = sum[2*CALC_BITS-1:0];
    end
    if (i_clr) begin
      a_d = '0;
    end
  end

  // a bus write opens its own half even without i_do
  assign lo_en = i_do | (i_wreg == REG_A_LO);
  assign hi_en = i_do | (i_wreg == REG_A_HI);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      a_q <= '0;
    end else begin
      if (lo_en) begin
        a_q[CALC_BITS-1:0] <= a_d[CALC_BITS-1:0];
      end
      if (hi_en) begin
        a_q[2*CALC_BITS-1:CALC_BITS] <= a_d[2*CALC_BITS-1:CALC_BITS];
      end
    end
  end

  assign o_a_lo = a_q[CALC_BITS-1:0];
  assign o_a_hi = a_q[2*CALC_BITS-1:CALC_BITS];

  // inverted carriage is meaningless unless the sum is used
  a_sub_exec: assert property (@(posedge clk) disable iff (!rst_n)
    i_sub |-> i_exec);

endmodule

// File: calc_regs.sv
// counter, carriage and output registers
`timescale 1ns/1ps

module calc_regs (
  input  logic                  clk,
  input  logic                  rst_n,
  input  calc_pkg::calc_word_t  i_x,       // operand x
  input  calc_pkg::calc_word_t  i_y,       // operand y
  input  logic                  i_load,    // take operands
  input  calc_pkg::calc_reg_t   i_rreg,    // bus source
  input  calc_pkg::calc_reg_t   i_wreg,    // bus sink
  input  calc_pkg::calc_xop_t   i_xop,
  input  logic                  i_x_shin,
  input  calc_pkg::calc_yop_t   i_yop,
  input  calc_pkg::calc_word_t  i_a_lo,    // accumulator halves for the mux
  input  calc_pkg::calc_word_t  i_a_hi,
  output calc_pkg::calc_word_t  o_bus,
  output calc_pkg::calc_dword_t o_y,
  output logic                  o_x_lsb,
  output calc_pkg::calc_word_t  o_result
);
  import calc_pkg::*;

  calc_word_t  x_q, x_d;   // counter
  calc_dword_t y_q, y_d;   // carriage
  calc_word_t  z_q, z_d;   // output

  //////////////////// bus

  // single word transfer mux
  always_comb begin
    case (i_rreg)
      REG_X:    o_bus = x_q;
      REG_Y_LO: o_bus = y_q[CALC_BITS-1:0];
      REG_Y_HI: o_bus = y_q[2*CALC_BITS-1:CALC_BITS];
      REG_A_LO: o_bus = i_a_lo;
      REG_A_HI: o_bus = i_a_hi;
      REG_Z:    o_bus = z_q;
      default:  o_bus = '0;  // REG_ZERO
    endcase
  end

  //////////////////// next state

  // X: bus write, then shift, then load
  always_comb begin
    x_d = x_q;
    if (i_wreg == REG_X) begin
      x_d = o_bus;
    end
    case (i_xop)
      XOP_SHL: x_d = {x_q[CALC_BITS-2:0], i_x_shin};  // quotient bit in
      XOP_SHR: x_d = {1'b0, x_q[CALC_BITS-1:1]};      // multiplier out
      default: ;
    endcase
    if (i_load) begin
      x_d = i_x;
    end
  end

  // Y: either half from bus, shifts act on both halves
  always_comb begin
    y_d = y_q;
    if (i_wreg == REG_Y_LO) begin
      y_d[CALC_BITS-1:0] = o_bus;
    end
    if (i_wreg == REG_Y_HI) begin
      y_d[2*CALC_BITS-1:CALC_BITS] = o_bus;
    end
    case (i_yop)
      YOP_SHL: y_d = {y_q[2*CALC_BITS-2:0], 1'b0};
      YOP_SHR: y_d = {1'b0, y_q[2*CALC_BITS-1:1]};
      // divisor lined up under the dividend msb
      YOP_SHW: y_d = {1'b0, y_q[CALC_BITS-1:0], {(CALC_BITS-1){1'b0}}};
      default: ;
    endcase
    if (i_load) begin
      y_d = {{CALC_BITS{1'b0}}, i_y};  // hi half cleared
    end
  end

  assign z_d = (i_wreg == REG_Z) ? o_bus : z_q;  // only ever fed from bus

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      x_q <= '0;
      y_q <= '0;
      z_q <= '0;
    end else begin
      x_q <= x_d;
      y_q <= y_d;
      z_q <= z_d;
    end
  end

  assign o_y      = y_q;
  assign o_x_lsb  = x_q[0];
  assign o_result = z_q;

  //////////////////// checks

  // Z is a sink, never copied back out to nowhere
  a_z_read: assert property (@(posedge clk) disable iff (!rst_n)
    (i_wreg == REG_ZERO) |-> (i_rreg != REG_Z));

  // operand load only from idle, no shifting then
  a_load_quiet: assert property (@(posedge clk) disable iff (!rst_n)
    i_load |-> (i_xop == XOP_NOP) && (i_yop == YOP_NOP));

endmodule

// File: calc_pkg.sv
// pinwheel calculator definitions
package calc_pkg;

  //////////////////// widths

  localparam int CALC_BITS     = 32;                // word width, 4 or more
  localparam int CALC_CNT_BITS = $clog2(CALC_BITS); // loop counter width

  typedef logic [CALC_BITS-1:0]     calc_word_t;    // one data word
  typedef logic [2*CALC_BITS-1:0]   calc_dword_t;   // Y and A width
  typedef logic [CALC_CNT_BITS-1:0] calc_cnt_t;

  //////////////////// commands

  typedef enum logic [2:0] {
    CALC_OP_ADD = 3'h0,  // sum, one word
    CALC_OP_SUB = 3'h1,  // difference, one word
    CALC_OP_MUL = 3'h2,  // product lo then hi
    CALC_OP_DIV = 3'h3   // quotient then remainder
  } calc_op_t;           // codes 4..7 run as add

  // bus register index
  typedef enum logic [2:0] {
    REG_ZERO = 3'h0,     // reads zero, never written
    REG_X    = 3'h1,     // counter
    REG_Y_LO = 3'h2,     // carriage
    REG_Y_HI = 3'h3,
    REG_A_LO = 3'h4,     // accumulator
    REG_A_HI = 3'h5,
    REG_Z    = 3'h6      // output word
  } calc_reg_t;

  typedef enum logic [1:0] {
    XOP_NOP = 2'h0,
    XOP_SHL = 2'h1,      // shin bit enters at bit 0
    XOP_SHR = 2'h2       // logical
  } calc_xop_t;

  typedef enum logic [1:0] {
    YOP_NOP = 2'h0,
    YOP_SHL = 2'h1,      // double width
    YOP_SHR = 2'h2,      // double width
    YOP_SHW = 2'h3       // lo word up by one word less one bit
  } calc_yop_t;

  //////////////////// sequencer

  typedef enum logic [3:0] {
    PH_RDY     = 4'h0,   // idle, operands load on start
    PH_START   = 4'h1,   // dispatch on command
    PH_ADD1    = 4'h2,
    PH_SUB1    = 4'h3,
    PH_MULLOOP = 4'h4,   // shift and add
    PH_MULOUT  = 4'h5,
    PH_DIVLOOP = 4'h6,   // restoring divide
    PH_DIVOUT  = 4'h7,
    PH_OUPA    = 4'h8,   // single word from A
    PH_OUP2A   = 4'h9,   // A lo shown, A hi next
    PH_OUP2B   = 4'ha,   // X shown, A lo next
    PH_OUPW    = 4'hb    // last word handshake
  } calc_phase_t;

endpackage
